// ==== x86_alu.f ====
+incdir+dv
rtl/x86_alu_pkg.sv
rtl/alu_arith.sv
rtl/alu_logic.sv
rtl/alu_daa.sv
rtl/alu32.sv
rtl/eflags_reg.sv
rtl/alu_ex_stage.sv
dv/tb_alu_ex_stage.sv

// ==== Bender.yml ====
package:
  name: x86_alu

sources:
  - files:
      - rtl/x86_alu_pkg.sv
      - rtl/alu_arith.sv
      - rtl/alu_logic.sv
      - rtl/alu_daa.sv
      - rtl/alu32.sv
      - rtl/eflags_reg.sv
      - rtl/alu_ex_stage.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_alu_ex_stage.sv

// ==== dv/tb_alu_ref.svh ====
// Reference model of x86 ALU results and status flags for the execute stage testbench
`ifndef TB_ALU_REF_SVH
`define TB_ALU_REF_SVH

// Even parity, set when the byte has an even count of ones
function automatic logic even_parity(input logic [7:0] v);
	int ones;
	ones = 0;
	for (int i = 0; i < 8; i++) begin
		ones += v[i];
	end
	return (ones % 2) == 0;
endfunction

// SF, ZF and PF of a 32-bit result
function automatic logic [31:0] result_flags(input logic [31:0] res);
	logic [31:0] fl;
	fl = '0;
	fl[FLAG_SF] = res[31];
	fl[FLAG_ZF] = (res == 32'd0);
	fl[FLAG_PF] = even_parity(res[7:0]);
	return fl;
endfunction

// ADD, or CMP as subtraction
function automatic logic [31:0] arith_model(input logic sub, input logic [31:0] a,
		input logic [31:0] b, output logic [31:0] res);
	logic [32:0] wide;
	logic [31:0] fl;
	fl = '0;
	if (sub) begin
		wide = {1'b0, a} - {1'b0, b};
		// Borrows out of the word and out of the low nibble
		fl[FLAG_CF] = (a < b);
		fl[FLAG_AF] = (a[3:0] < b[3:0]);
		fl[FLAG_OF] = (a[31] != b[31]) && (wide[31] != a[31]);
	end else begin
		wide = {1'b0, a} + {1'b0, b};
		fl[FLAG_CF] = wide[32];
		fl[FLAG_AF] = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15;
		fl[FLAG_OF] = (a[31] == b[31]) && (wide[31] != a[31]);
	end
	res = wide[31:0];
	return fl | result_flags(res);
endfunction

// AND, OR and NOT, logical ops clear OF, CF and AF
function automatic logic [31:0] logic_model(input alu_op_e op, input logic [31:0] a,
		input logic [31:0] b, output logic [31:0] res);
	case (op)
		OP_AND: res = a & b;
		OP_OR:  res = a | b;
		default: res = ~a;
	endcase
	return result_flags(res);
endfunction

// DAA on AL with the carries left by the previous op
function automatic logic [31:0] daa_model(input logic [7:0] al, input logic cf,
		input logic af, output logic [31:0] res);
	logic [7:0]  v;
	logic [31:0] fl;
	fl = '0;
	v  = al;
	if (al[3:0] > 4'd9 || af) begin
		v = v + 8'h06;
		fl[FLAG_AF] = 1'b1;
	end
	// Decided on the original AL
	if (al > 8'h99 || cf) begin
		v = v + 8'h60;
		fl[FLAG_CF] = 1'b1;
	end
	fl[FLAG_SF] = v[7];
	fl[FLAG_ZF] = (v == 8'd0);
	fl[FLAG_PF] = even_parity(v);
	res = {24'd0, v};
	return fl;
endfunction

// Decimal sum of two packed BCD bytes, carry in bit 8
function automatic logic [8:0] bcd_sum(input logic [7:0] a, input logic [7:0] b);
	int dec;
	dec = a[7:4] * 10 + a[3:0] + b[7:4] * 10 + b[3:0];
	return {dec >= 100, 4'((dec % 100) / 10), 4'(dec % 10)};
endfunction

`endif

// ==== dv/tb_alu_ex_stage.sv ====
// Testbench for the x86 ALU execute stage with reference model and assertions
`timescale 1ns/10ps

module tb_alu_ex_stage;
	import x86_alu_pkg::*;

	`include "tb_alu_ref.svh"

	localparam int CLK_PERIOD = 20;
	localparam int N_RAND     = 8;
	localparam int N_STREAM   = 40;
	// Requests over all tests, sets the watchdog
	localparam int N_REQ = 30 + 5 * N_RAND + N_STREAM;

	// Expected response and flags after one request
	typedef struct packed {
		logic [31:0] result;
		logic        wr_result;
		logic [31:0] flags;
	} exp_t;

	logic     clk;
	logic     arst_n;
	logic     req_valid;
	alu_req_t req;
	logic     rsp_valid;
	alu_rsp_t rsp;
	eflags_u  flags;

	logic [31:0] model_flags = FLAGS_RESET;
	exp_t        exp_q [$];
	exp_t        exp_entry;
	exp_t        popped;
	string       test_name = "reset";
	int          value_errs = 0;
	int          proto_errs = 0;
	int          sent_count = 0;
	int          rsp_count = 0;

	alu_ex_stage UUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.req_valid (req_valid),
		.req       (req),
		.rsp_valid (rsp_valid),
		.rsp       (rsp),
		.flags     (flags)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Run length plus margin for reset and drain
	initial begin
		#((N_REQ + 20) * CLK_PERIOD);
		$display("Watchdog expired before all responses were checked");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	task automatic report_mismatch(input string what, input logic [31:0] expv,
			input logic [31:0] actv);
		value_errs++;
		$display("[ERROR] %s: %s expected %h actual %h", test_name, what, expv, actv);
	endtask

	task automatic protocol_fault(input string msg);
		proto_errs++;
		$display("Protocol failure in %s: %s", test_name, msg);
	endtask

	//------------------------------
	// Expectation pipeline
	//------------------------------

	// Follows the DUT response register, one entry per accepted request
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			exp_entry <= '{result: '0, wr_result: 1'b0, flags: FLAGS_RESET};
		end else if (req_valid) begin
			if (exp_q.size() == 0) begin
				protocol_fault("no expected response queued for an accepted request");
			end else begin
				popped = exp_q.pop_front();
				exp_entry <= popped;
			end
		end
	end

	always @(negedge clk) begin
		if (arst_n && rsp_valid) begin
			rsp_count++;
		end
	end

	a_rsp_follows_req: assert property (@(posedge clk) disable iff (!arst_n)
		req_valid |=> rsp_valid)
		else protocol_fault("rsp_valid missing one cycle after req_valid");
	a_no_extra_rsp: assert property (@(posedge clk) disable iff (!arst_n)
		!req_valid |=> !rsp_valid)
		else protocol_fault("rsp_valid raised without a request");
	a_wr_result: assert property (@(posedge clk) disable iff (!arst_n)
		rsp_valid |-> rsp.wr_result == exp_entry.wr_result)
		else report_mismatch("wr_result", $sampled(exp_entry.wr_result),
			$sampled(rsp.wr_result));
	// CMP returns the difference, CLD and STD return zero
	a_result: assert property (@(posedge clk) disable iff (!arst_n)
		rsp_valid |-> rsp.result == exp_entry.result)
		else report_mismatch("result", $sampled(exp_entry.result), $sampled(rsp.result));
	a_flags: assert property (@(posedge clk) disable iff (!arst_n)
		flags.raw == exp_entry.flags)
		else report_mismatch("flags", $sampled(exp_entry.flags), $sampled(flags.raw));

	//------------------------------
	// Stimulus
	//------------------------------

	// Model one request, queue its expectation, drive it on the falling edge
	task automatic send_req(input alu_op_e op, input logic [31:0] a, input logic [31:0] b);
		logic [31:0] res;
		logic [31:0] new_fl;
		logic [31:0] mask;
		logic        wr;
		exp_t        entry;
		res    = '0;
		mask   = STATUS_MASK;
		wr     = 1'b1;
		case (op)
			OP_ADD: new_fl = arith_model(1'b0, a, b, res);
			OP_CMP: begin
				new_fl = arith_model(1'b1, a, b, res);
				wr     = 1'b0;
			end
			OP_DAA: new_fl = daa_model(a[7:0], model_flags[FLAG_CF], model_flags[FLAG_AF], res);
			OP_CLD, OP_STD: begin
				new_fl = (op == OP_STD) ? DF_MASK : 32'd0;
				mask   = DF_MASK;
				wr     = 1'b0;
			end
			default: begin
				new_fl = logic_model(op, a, b, res);
				// NOT owns no flag
				if (op == OP_NOT) begin
					mask = '0;
				end
			end
		endcase
		model_flags = (model_flags & ~mask) | (new_fl & mask);
		entry = '{result: res, wr_result: wr, flags: model_flags};
		exp_q.push_back(entry);
		@(negedge clk);
		req_valid = 1'b1;
		req       = '{op: op, a: a, b: b};
		sent_count++;
	endtask

	task automatic check_reset_state();
		assert (rsp_valid == 1'b0) else report_mismatch("rsp_valid", 32'd0, 32'(rsp_valid));
		assert (rsp == '0) else report_mismatch("rsp.result", 32'd0, rsp.result);
		assert (flags.raw == FLAGS_RESET) else report_mismatch("flags", FLAGS_RESET, flags.raw);
	endtask

	task automatic arith_corners();
		test_name = "add_cmp";
		// DF set first, CMP must keep it
		send_req(OP_STD, 0, 0);
		send_req(OP_ADD, 32'h0000_0000, 32'h0000_0000);
		send_req(OP_ADD, 32'h7FFF_FFFF, 32'h0000_0001);
		send_req(OP_ADD, 32'hFFFF_FFFF, 32'h0000_0001);
		send_req(OP_CMP, 32'h1234_5678, 32'h1234_5678);
		send_req(OP_CMP, 32'h0000_0000, 32'h0000_0001);
		send_req(OP_CMP, 32'h8000_0000, 32'h0000_0001);
		for (int i = 0; i < N_RAND; i++) begin
			send_req(OP_ADD, $urandom(), $urandom());
			send_req(OP_CMP, $urandom(), $urandom());
		end
		send_req(OP_CLD, 0, 0);
	endtask

	task automatic logic_ops();
		test_name = "logic";
		// Leaves CF set ahead of NOT
		send_req(OP_ADD, 32'hFFFF_FFFF, 32'h0000_0001);
		send_req(OP_NOT, 32'h0F0F_0000, 32'h0);
		send_req(OP_AND, 32'hF0F0_F0F0, 32'h0F0F_0F0F);
		send_req(OP_OR, 32'h8000_0000, 32'h0000_0001);
		for (int i = 0; i < N_RAND; i++) begin
			send_req(OP_AND, $urandom(), $urandom());
			send_req(OP_OR, $urandom(), $urandom());
			send_req(OP_NOT, $urandom(), $urandom());
		end
	endtask

	// BCD add then DAA, last pair carries out of bit 31
	task automatic bcd_adjust();
		logic [31:0] add_a [5];
		logic [31:0] add_b [5];
		logic [31:0] res;
		logic [31:0] fl;
		logic [31:0] daa_res;
		logic [8:0]  dec;
		test_name = "daa";
		add_a = '{32'h38, 32'h99, 32'h09, 32'h55, 32'hFFFF_FF90};
		add_b = '{32'h45, 32'h01, 32'h08, 32'h55, 32'h70};
		for (int i = 0; i < 5; i++) begin
			send_req(OP_ADD, add_a[i], add_b[i]);
			void'(arith_model(1'b0, add_a[i], add_b[i], res));
			fl  = daa_model(res[7:0], model_flags[FLAG_CF], model_flags[FLAG_AF], daa_res);
			dec = bcd_sum(add_a[i][7:0], add_b[i][7:0]);
			assert (daa_res[7:0] == dec[7:0] && fl[FLAG_CF] == dec[8])
				else report_mismatch("decimal sum", 32'(dec), {fl[FLAG_CF], daa_res[7:0]});
			send_req(OP_DAA, res, $urandom());
		end
	endtask

	task automatic direction_flag();
		test_name = "direction";
		send_req(OP_STD, 0, 0);
		send_req(OP_ADD, $urandom(), $urandom());
		send_req(OP_ADD, $urandom(), $urandom());
		send_req(OP_CMP, $urandom(), $urandom());
		send_req(OP_CLD, 0, 0);
		send_req(OP_ADD, $urandom(), $urandom());
		send_req(OP_STD, 0, 0);
		send_req(OP_DAA, $urandom(), 0);
	endtask

	task automatic random_stream();
		test_name = "stream";
		for (int i = 0; i < N_STREAM; i++) begin
			send_req(alu_op_e'($urandom_range(7, 0)), $urandom(), $urandom());
		end
	endtask

	// Stop driving and wait until every expectation has been checked
	task automatic drain();
		@(negedge clk);
		req_valid = 1'b0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		repeat (2) @(negedge clk);
	endtask

	initial begin
		arst_n    = 1'b0;
		req_valid = 1'b0;
		req       = '0;
		void'($urandom(32'he41ac2e0));
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		check_reset_state();
		arith_corners();
		logic_ops();
		bcd_adjust();
		direction_flag();
		random_stream();
		drain();
		test_name = "summary";
		// One response per request
		assert (rsp_count == sent_count)
			else protocol_fault($sformatf("%0d responses for %0d requests", rsp_count, sent_count));
		$display("Summary: %0d requests, %0d responses, %0d value errors, %0d protocol errors",
			sent_count, rsp_count, value_errs, proto_errs);
		if (value_errs + proto_errs == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== rtl/alu_ex_stage.sv ====
// Execute stage integer unit with registered result and EFLAGS
`timescale 1ns/10ps

module alu_ex_stage (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  req_valid,
	input  x86_alu_pkg::alu_req_t req,
	output logic                  rsp_valid,
	output x86_alu_pkg::alu_rsp_t rsp,
	output x86_alu_pkg::eflags_u  flags
);
	import x86_alu_pkg::*;

	//------------------------------
	// ALU
	//------------------------------

	logic [31:0] alu_result;
	eflags_u     alu_flags;
	logic [31:0] alu_mask;
	logic        alu_wr_result;

	// Request feeds the ALU directly, no input register
	alu32 u_alu32 (
		.req       (req),
		.cur_flags (flags),
		.result    (alu_result),
		.new_flags (alu_flags),
		.flag_mask (alu_mask),
		.wr_result (alu_wr_result)
	);

	//------------------------------
	// Flags register
	//------------------------------

	// Written on the same edge as the response
	eflags_reg u_eflags_reg (
		.clk    (clk),
		.arst_n (arst_n),
		.we     (req_valid),
		.wdata  (alu_flags),
		.mask   (alu_mask),
		.flags  (flags)
	);

	//------------------------------
	// Response register
	//------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rsp_valid <= 1'b0;
			rsp       <= '0;
		end else begin
			// One-cycle strobe, one cycle after the request
			rsp_valid <= req_valid;
			if (req_valid) begin
				rsp.result    <= alu_result;
				rsp.wr_result <= alu_wr_result;
			end
		end
	end

endmodule

// ==== rtl/eflags_reg.sv ====
// Architectural EFLAGS register with per-bit masked update
`timescale 1ns/10ps

module eflags_reg (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 we,
	input  x86_alu_pkg::eflags_u wdata,
	input  logic [31:0]          mask,
	output x86_alu_pkg::eflags_u flags
);
	import x86_alu_pkg::*;

	//------------------------------
	// Merge
	//------------------------------

	// Next word, masked bits from wdata, rest held
	logic [31:0] merged;

	always_comb begin
		merged = (flags.raw & ~mask) | (wdata.raw & mask);
		// Reserved bit 1 always one
		merged[FLAG_RSVD1] = 1'b1;
	end

	//------------------------------
	// Storage
	//------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags.raw <= FLAGS_RESET;
		end else if (we) begin
			// Visible to the next request one cycle later
			flags.raw <= merged;
		end
	end

endmodule

// ==== rtl/alu32.sv ====
// Combinational 32-bit x86 ALU with opcode select and flag write mask
`timescale 1ns/10ps

module alu32 (
	input  x86_alu_pkg::alu_req_t req,
	input  x86_alu_pkg::eflags_u  cur_flags,
	output logic [31:0]           result,
	output x86_alu_pkg::eflags_u  new_flags,
	output logic [31:0]           flag_mask,
	output logic                  wr_result
);
	import x86_alu_pkg::*;

	//------------------------------
	// Unit outputs
	//------------------------------

	logic [31:0] arith_result;
	eflags_u     arith_flags;
	logic [31:0] logic_result;
	eflags_u     logic_flags;
	logic [31:0] daa_result;
	eflags_u     daa_flags;
	// CMP shares the adder in subtract mode
	logic        is_cmp;

	assign is_cmp = (req.op == OP_CMP);

	alu_arith u_alu_arith (
		.sub    (is_cmp),
		.a      (req.a),
		.b      (req.b),
		.result (arith_result),
		.flags  (arith_flags)
	);

	alu_logic u_alu_logic (
		.op     (req.op),
		.a      (req.a),
		.b      (req.b),
		.result (logic_result),
		.flags  (logic_flags)
	);

	// DAA takes CF and AF from the architectural register
	alu_daa u_alu_daa (
		.al     (req.a[7:0]),
		.cf_in  (cur_flags.f.cf),
		.af_in  (cur_flags.f.af),
		.result (daa_result),
		.flags  (daa_flags)
	);

	//------------------------------
	// Select and mask
	//------------------------------

	always_comb begin
		// CLD and STD defaults, zero result
		result    = '0;
		new_flags = '0;
		flag_mask = '0;
		wr_result = 1'b1;

		unique case (req.op)
			OP_ADD, OP_CMP: begin
				result    = arith_result;
				new_flags = arith_flags;
				flag_mask = STATUS_MASK;
				// Compare only sets flags
				wr_result = ~is_cmp;
			end
			OP_AND, OP_OR: begin
				result    = logic_result;
				new_flags = logic_flags;
				flag_mask = STATUS_MASK;
			end
			OP_NOT: begin
				// No flag is touched
				result    = logic_result;
				new_flags = logic_flags;
			end
			OP_DAA: begin
				result    = daa_result;
				new_flags = daa_flags;
				flag_mask = STATUS_MASK;
			end
			OP_CLD, OP_STD: begin
				new_flags.f.df = (req.op == OP_STD);
				flag_mask      = DF_MASK;
				wr_result      = 1'b0;
			end
		endcase
	end

endmodule

// ==== rtl/alu_daa.sv ====
// Decimal adjust of AL after a packed BCD addition
`timescale 1ns/10ps

module alu_daa (
	input  logic [7:0]           al,
	input  logic                 cf_in,
	input  logic                 af_in,
	output logic [31:0]          result,
	output x86_alu_pkg::eflags_u flags
);

	//------------------------------
	// Adjust decisions
	//------------------------------

	// Both tests look at the original AL
	logic       lo_adj;
	logic       hi_adj;
	// Correction terms
	logic [7:0] lo_add;
	logic [7:0] hi_add;
	// Adjusted byte, wraps modulo 256
	logic [7:0] al_adj;

	// Low digit out of BCD range or a nibble carry happened
	assign lo_adj = (al[3:0] > 4'd9) | af_in;

	// High digit overflow or a byte carry happened
	assign hi_adj = (al > 8'h99) | cf_in;

	assign lo_add = lo_adj ? 8'h06 : 8'h00;
	assign hi_add = hi_adj ? 8'h60 : 8'h00;

	//------------------------------
	// Result
	//------------------------------

	assign al_adj = al + lo_add + hi_add;

	// Only AL is written, upper bits zero
	assign result = {24'd0, al_adj};

	//------------------------------
	// Flags
	//------------------------------

	always_comb begin
		// OF stays zero along with reserved bits
		flags.raw = '0;

		// CF set only by the high adjust step
		flags.f.cf = hi_adj;
		flags.f.af = lo_adj;

		// Sign, zero and parity from the adjusted byte
		flags.f.sf = al_adj[7];
		flags.f.zf = (al_adj == 8'd0);
		flags.f.pf = ~^al_adj;
	end

endmodule

// ==== rtl/alu_logic.sv ====
// Bitwise AND, OR and NOT unit with logical status flags
`timescale 1ns/10ps

module alu_logic (
	input  x86_alu_pkg::alu_op_e op,
	input  logic [31:0]          a,
	input  logic [31:0]          b,
	output logic [31:0]          result,
	output x86_alu_pkg::eflags_u flags
);
	import x86_alu_pkg::*;

	//------------------------------
	// Operation
	//------------------------------

	always_comb begin
		unique case (op)
			OP_AND: result = a & b;
			OP_OR:  result = a | b;
			// NOT ignores the second operand
			OP_NOT: result = ~a;
			default: result = '0;
		endcase
	end

	//------------------------------
	// Flags
	//------------------------------

	always_comb begin
		// OF, CF and AF cleared by AND and OR
		flags.raw = '0;

		flags.f.sf = result[31];
		flags.f.zf = (result == 32'd0);
		// Even parity of low byte
		flags.f.pf = ~^result[7:0];
		// NOT produces the same word but its mask is zero
	end

endmodule

// ==== rtl/alu_arith.sv ====
// Integer adder/subtractor for ADD and CMP with x86 status flags
`timescale 1ns/10ps

module alu_arith (
	input  logic                 sub,
	input  logic [31:0]          a,
	input  logic [31:0]          b,
	output logic [31:0]          result,
	output x86_alu_pkg::eflags_u flags
);

	//------------------------------
	// Datapath
	//------------------------------

	// Second operand, inverted for subtraction
	logic [31:0] b_eff;
	// One extra bit for the carry out of bit 31
	logic [32:0] sum;
	logic        carry_out;
	// Sign rule inputs
	logic        same_sign_in;
	logic        sign_flip;

	assign b_eff = sub ? ~b : b;

	// Subtract as a + ~b + 1
	assign sum = {1'b0, a} + {1'b0, b_eff} + {32'd0, sub};

	assign result    = sum[31:0];
	assign carry_out = sum[32];

	// Overflow when both inputs share a sign the result lost
	assign same_sign_in = (a[31] == b_eff[31]);
	assign sign_flip    = (result[31] != a[31]);

	//------------------------------
	// Flags
	//------------------------------

	always_comb begin
		// Reserved and non-status bits stay zero
		flags.raw = '0;

		// Carry on add, borrow on subtract
		flags.f.cf = carry_out ^ sub;

		// Nibble carry or borrow into bit 4
		// Same XOR form serves add and subtract with the original b
		flags.f.af = a[4] ^ b[4] ^ result[4];

		flags.f.of = same_sign_in & sign_flip;
		flags.f.sf = result[31];
		flags.f.zf = (result == 32'd0);

		// Even parity over the low byte only
		flags.f.pf = ~^result[7:0];
	end

endmodule

// ==== rtl/x86_alu_pkg.sv ====
// x86 ALU package with opcodes, EFLAGS layout, request and response types

package x86_alu_pkg;

	//------------------------------
	// Opcodes
	//------------------------------

	// Same 3-bit encoding as the execute-stage ALU select
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_OR  = 3'd1,
		OP_NOT = 3'd2,
		OP_DAA = 3'd3,
		OP_AND = 3'd4,
		OP_CLD = 3'd5,
		OP_CMP = 3'd6,
		OP_STD = 3'd7
	} alu_op_e;

	//------------------------------
	// EFLAGS bit positions
	//------------------------------

	localparam int unsigned FLAG_CF    = 0;
	// Reserved, always reads one
	localparam int unsigned FLAG_RSVD1 = 1;
	localparam int unsigned FLAG_PF    = 2;
	localparam int unsigned FLAG_AF    = 4;
	localparam int unsigned FLAG_ZF    = 6;
	localparam int unsigned FLAG_SF    = 7;
	localparam int unsigned FLAG_DF    = 10;
	localparam int unsigned FLAG_OF    = 11;

	// Value after reset, only the reserved one bit set
	localparam logic [31:0] FLAGS_RESET = 32'd1 << FLAG_RSVD1;

	// Arithmetic status flags owned by ADD, CMP, DAA, AND and OR
	localparam logic [31:0] STATUS_MASK = (32'd1 << FLAG_CF) | (32'd1 << FLAG_PF) |
		(32'd1 << FLAG_AF) | (32'd1 << FLAG_ZF) | (32'd1 << FLAG_SF) | (32'd1 << FLAG_OF);

	// Direction flag, owned by CLD and STD
	localparam logic [31:0] DF_MASK = 32'd1 << FLAG_DF;

	//------------------------------
	// EFLAGS word
	//------------------------------

	// Field view, MSB first
	typedef struct packed {
		logic [19:0] rsvd_31_12;
		logic        of;
		logic        df;
		logic [1:0]  rsvd_9_8;
		logic        sf;
		logic        zf;
		logic        rsvd_5;
		logic        af;
		logic        rsvd_3;
		logic        pf;
		logic        rsvd_1;
		logic        cf;
	} eflags_t;

	// Raw word for masked writes, field view for reads
	typedef union packed {
		logic [31:0] raw;
		eflags_t     f;
	} eflags_u;

	//------------------------------
	// Request and response
	//------------------------------

	// 67-bit request
	typedef struct packed {
		alu_op_e     op;
		logic [31:0] a;
		logic [31:0] b;
	} alu_req_t;

	// Low wr_result for CMP, CLD and STD
	typedef struct packed {
		logic [31:0] result;
		logic        wr_result;
	} alu_rsp_t;

endpackage
